/* common/icache_geom_pkg.sv */
`default_nettype none

package icache_geom_pkg;

	// address split of a 32-bit fetch address
	localparam int tag_w    = 20;
	localparam int index_w  = 6;
	localparam int offset_w = 4;

	// derived cache shape
	localparam int num_sets       = 1 << index_w;
	localparam int words_per_line = 1 << offset_w;
	localparam int num_ways       = 2;

	// cpu address as seen by every lookup
	typedef struct packed {
		logic [tag_w-1:0]    tag;
		logic [index_w-1:0]  index;
		logic [offset_w-1:0] offset;
		// always 0 for word fetches
		logic [1:0]          byte_off;
	} icache_addr_t;

	// one refill write, broadcast to both ways
	typedef struct packed {
		logic                        we;
		// target way, only that way takes the write
		logic [$clog2(num_ways)-1:0] way;
		logic [index_w-1:0]          index;
		logic [offset_w-1:0]         offset;
		logic [31:0]                 word;
		// tag to store once the line is complete
		logic [tag_w-1:0]            tag;
		// final word of the line
		logic                        last;
	} fill_wr_t;

endpackage

`default_nettype wire

/* common/icache_axi_pkg.sv */
`default_nettype none

package icache_axi_pkg;

	// one refill = one incr burst of full words
	localparam int burst_beats = 16;

	// read address channel, line aligned
	typedef struct packed {
		logic [31:0] addr;
	} axi_ar_t;

	// read data channel payload
	typedef struct packed {
		logic [31:0] data;
		// set on the 16th beat
		logic        last;
	} axi_r_t;

endpackage

`default_nettype wire

/* rtl/icache_data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_data_ram
	import icache_geom_pkg::*;
(
	input  logic                        clk,
	input  logic                        we,
	input  logic [index_w+offset_w-1:0] waddr,
	input  logic [31:0]                 wdata,
	input  logic [index_w+offset_w-1:0] raddr,
	output logic [31:0]                 rdata
);

	// all words of one way, addressed by {index, offset}
	logic [31:0] mem [num_sets*words_per_line];

	// refill write port
	always_ff @(posedge clk)
	begin
		if (we)
		begin
			mem[waddr] <= wdata;
		end
	end

	// registered read, word valid one cycle after raddr
	always_ff @(posedge clk)
	begin
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

/* rtl/icache_way/icache_way.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_way
	import icache_geom_pkg::*;
#(
	parameter logic way_id = 1'b0
)
(
	input  logic         clk,
	input  logic         rst_n,
	input  icache_addr_t lookup_addr,
	input  fill_wr_t     fill,
	output logic         hit,
	output logic [31:0]  rdata
);

	// per set tag and valid, kept in flops for a same cycle compare
	logic [tag_w-1:0]    tag_q [num_sets];
	logic [num_sets-1:0] valid_q;

	// this way's share of the refill writes
	logic own_wr;
	logic own_last;

	assign own_wr   = fill.we && (fill.way == way_id);
	assign own_last = own_wr && fill.last;

	// hit check on the live cpu address
	assign hit = valid_q[lookup_addr.index] && (tag_q[lookup_addr.index] == lookup_addr.tag);

	// tag written once, with the last word
	always_ff @(posedge clk)
	begin
		if (own_last)
		begin
			tag_q[fill.index] <= fill.tag;
		end
	end

	// line becomes valid only when all 16 words are in
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			valid_q <= '0;
		end
		else if (own_last)
		begin
			valid_q[fill.index] <= 1'b1;
		end
	end

	// data words, written beat by beat during refill
	icache_data_ram data_ram_i (
		.clk   (clk),
		.we    (own_wr),
		.waddr ({fill.index, fill.offset}),
		.wdata (fill.word),
		.raddr ({lookup_addr.index, lookup_addr.offset}),
		.rdata (rdata)
	);

endmodule

`default_nettype wire

/* rtl/icache_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_lookup
	import icache_geom_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         cpu_re,
	input  icache_addr_t cpu_addr,
	input  logic         hit0,
	input  logic         hit1,
	input  logic [31:0]  rdata0,
	input  logic [31:0]  rdata1,
	input  logic         refill_busy,
	input  fill_wr_t     fill,
	output logic         miss,
	output logic         victim_way,
	output logic         cpu_stall,
	output logic [31:0]  cpu_rdata
);

	// one bit per set, names the least recently used way
	logic [num_sets-1:0] lru_q;
	// way that hit last accepted request
	logic sel_q;
	logic any_hit;
	logic accept;

	assign any_hit = hit0 || hit1;

	// new miss only while the refill engine is free
	assign miss      = cpu_re && !any_hit && !refill_busy;
	assign cpu_stall = miss || refill_busy;
	assign accept    = cpu_re && !cpu_stall;

	// victim for a miss on this set
	assign victim_way = lru_q[cpu_addr.index];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			lru_q <= '0;
		end
		else if (fill.we && fill.last)
		begin
			// freshly filled way is the most recent one
			lru_q[fill.index] <= ~fill.way;
		end
		else if (accept)
		begin
			// point away from the way that just hit
			lru_q[cpu_addr.index] <= ~hit1;
		end
	end

	// ram word arrives a cycle late, so the mux select does too
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			sel_q <= 1'b0;
		end
		else if (accept)
		begin
			sel_q <= hit1;
		end
	end

	assign cpu_rdata = sel_q ? rdata1 : rdata0;

endmodule

`default_nettype wire

/* rtl/icache_refill/icache_refill_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_refill_fsm
	import icache_geom_pkg::*;
	import icache_axi_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         miss,
	input  logic         victim_way,
	input  icache_addr_t cpu_addr,
	input  logic         bus_grnt,
	input  logic         ar_ready,
	input  axi_r_t       r,
	input  logic         r_valid,
	output logic         bus_req,
	output axi_ar_t      ar,
	output logic         ar_valid,
	output logic         r_ready,
	output logic         refill_busy,
	output fill_wr_t     fill
);

	// idle, wait for grant, address phase, data phase
	typedef enum logic [1:0] {
		st_idle,
		st_req,
		st_addr,
		st_data
	} state_t;

	state_t state_q;
	state_t state_d;

	// line being refilled, captured at the miss
	logic [tag_w-1:0]   tag_q;
	logic [index_w-1:0] index_q;
	logic               way_q;

	// beat counter doubles as word offset
	logic [offset_w-1:0] beat_q;
	logic                beat_ok;
	logic                beat_last;

	// r_ready is high all through st_data, so r_valid alone moves a beat
	assign beat_ok   = (state_q == st_data) && r_valid;
	assign beat_last = (beat_q == offset_w'(burst_beats - 1));

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			st_idle:
			begin
				if (miss)
				begin
					state_d = st_req;
				end
			end
			st_req:
			begin
				if (bus_grnt)
				begin
					state_d = st_addr;
				end
			end
			st_addr:
			begin
				if (ar_ready)
				begin
					state_d = st_data;
				end
			end
			st_data:
			begin
				if (beat_ok && beat_last)
				begin
					state_d = st_idle;
				end
			end
			default:
			begin
				state_d = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state_q <= st_idle;
			beat_q  <= '0;
		end
		else
		begin
			state_q <= state_d;
			if (state_q == st_idle)
			begin
				beat_q <= '0;
			end
			else if (beat_ok)
			begin
				beat_q <= beat_q + 1'b1;
			end
		end
	end

	// refill target and victim, taken from the missing fetch
	always_ff @(posedge clk)
	begin
		if ((state_q == st_idle) && miss)
		begin
			tag_q   <= cpu_addr.tag;
			index_q <= cpu_addr.index;
			way_q   <= victim_way;
		end
	end

	// bus side, all straight from state
	assign bus_req     = (state_q != st_idle);
	assign refill_busy = (state_q != st_idle);
	assign ar_valid    = (state_q == st_addr);
	assign r_ready     = (state_q == st_data);

	// line aligned burst start
	assign ar = {tag_q, index_q, {offset_w{1'b0}}, 2'b00};

	// each accepted beat goes straight into the victim way
	always_comb
	begin
		fill        = '0;
		fill.we     = beat_ok;
		fill.way    = way_q;
		fill.index  = index_q;
		fill.offset = beat_q;
		fill.word   = r.data;
		fill.tag    = tag_q;
		fill.last   = beat_ok && beat_last;
	end

endmodule

`default_nettype wire

/* rtl/icache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_top
	import icache_geom_pkg::*;
	import icache_axi_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	// cpu fetch side
	input  logic         cpu_re,
	input  icache_addr_t cpu_addr,
	output logic         cpu_stall,
	output logic [31:0]  cpu_rdata,
	// bus arbitration
	output logic         bus_req,
	input  logic         bus_grnt,
	// axi read address
	output axi_ar_t      ar,
	output logic         ar_valid,
	input  logic         ar_ready,
	// axi read data
	input  axi_r_t       r,
	input  logic         r_valid,
	output logic         r_ready
);

	logic        hit0;
	logic        hit1;
	logic [31:0] rdata0;
	logic [31:0] rdata1;
	logic        miss;
	logic        victim_way;
	logic        refill_busy;
	// refill writes, seen by both ways and the lru
	fill_wr_t    fill;

	icache_way #(.way_id(1'b0)) way0_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.lookup_addr (cpu_addr),
		.fill        (fill),
		.hit         (hit0),
		.rdata       (rdata0)
	);

	icache_way #(.way_id(1'b1)) way1_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.lookup_addr (cpu_addr),
		.fill        (fill),
		.hit         (hit1),
		.rdata       (rdata1)
	);

	icache_lookup lookup_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.cpu_re      (cpu_re),
		.cpu_addr    (cpu_addr),
		.hit0        (hit0),
		.hit1        (hit1),
		.rdata0      (rdata0),
		.rdata1      (rdata1),
		.refill_busy (refill_busy),
		.fill        (fill),
		.miss        (miss),
		.victim_way  (victim_way),
		.cpu_stall   (cpu_stall),
		.cpu_rdata   (cpu_rdata)
	);

	icache_refill_fsm refill_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.miss        (miss),
		.victim_way  (victim_way),
		.cpu_addr    (cpu_addr),
		.bus_grnt    (bus_grnt),
		.ar_ready    (ar_ready),
		.r           (r),
		.r_valid     (r_valid),
		.bus_req     (bus_req),
		.ar          (ar),
		.ar_valid    (ar_valid),
		.r_ready     (r_ready),
		.refill_busy (refill_busy),
		.fill        (fill)
	);

endmodule

`default_nettype wire

/* dv/icache_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_assertions
	import icache_geom_pkg::*;
	import icache_axi_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         cpu_re,
	input  icache_addr_t cpu_addr,
	input  logic         cpu_stall,
	input  logic [31:0]  cpu_rdata,
	input  logic         bus_req,
	input  axi_ar_t      ar,
	input  logic         ar_valid,
	input  logic         ar_ready,
	input  axi_r_t       r,
	input  logic         r_valid,
	input  logic         r_ready
);

	// failures so far, read by the testbench summary
	int fail_cnt = 0;

	logic [31:0] word_addr;
	logic        last_beat;

	// word aligned fetch address
	assign word_addr = {cpu_addr[31:2], 2'b00};
	assign last_beat = r_valid && r_ready && r.last;

	// whole bus side quiet in the first cycle out of reset
	reset_idle: assert property (@(posedge clk)
		$rose(rst_n) |-> !bus_req && !ar_valid && !r_ready && !cpu_stall)
		else begin fail_cnt++; $error("bus or stall active right after reset"); end

	// stall without a busy refill is a fresh miss
	miss_requests: assert property (@(posedge clk) disable iff (!rst_n)
		(cpu_re && cpu_stall && !bus_req) |=> bus_req)
		else begin fail_cnt++; $error("miss did not raise bus_req"); end

	// burst starts at the line base
	ar_line_base: assert property (@(posedge clk) disable iff (!rst_n)
		ar_valid |-> ar.addr == {word_addr[31:6], 6'b0})
		else begin fail_cnt++; $error("ar address is not the line base"); end

	// address held until accepted
	ar_held: assert property (@(posedge clk) disable iff (!rst_n)
		(ar_valid && !ar_ready) |=> ar_valid && $stable(ar.addr))
		else begin fail_cnt++; $error("ar dropped or changed before ar_ready"); end

	// memory only offers beats in the data phase, where r_ready stays up
	r_ready_held: assert property (@(posedge clk) disable iff (!rst_n)
		r_valid |-> r_ready)
		else begin fail_cnt++; $error("beat offered while r_ready low"); end

	// memory word is the inverse of its address
	rdata_ok: assert property (@(posedge clk) disable iff (!rst_n)
		(cpu_re && !cpu_stall) |=> cpu_rdata == ~$past(word_addr))
		else begin fail_cnt++; $error("wrong cpu_rdata"); end

	// bus released right after last
	req_drops: assert property (@(posedge clk) disable iff (!rst_n)
		last_beat |=> !bus_req)
		else begin fail_cnt++; $error("bus_req still high after last beat"); end

	// held read hits in the same cycle
	stall_drops: assert property (@(posedge clk) disable iff (!rst_n)
		(last_beat && cpu_re) |=> !cpu_stall)
		else begin fail_cnt++; $error("stall still high after last beat"); end

endmodule

`default_nettype wire

/* dv/icache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_tb
	import icache_geom_pkg::*;
	import icache_axi_pkg::*;
();

	logic         clk = 1'b0;
	logic         rst_n = 1'b0;
	logic         cpu_re = 1'b0;
	icache_addr_t cpu_addr = '0;
	logic         cpu_stall;
	logic [31:0]  cpu_rdata;
	logic         bus_req;
	logic         bus_grnt = 1'b0;
	axi_ar_t      ar;
	logic         ar_valid;
	logic         ar_ready = 1'b0;
	axi_r_t       r = '0;
	logic         r_valid = 1'b0;
	logic         r_ready;

	// random source for the memory model only
	logic [31:0] lfsr_q = 32'hc094_86a0;

	// memory model state
	logic [1:0]  mem_phase = 2'd0;
	int unsigned mem_cnt;
	logic [31:0] mem_base;
	logic [31:0] mem_beat;

	// bookkeeping
	int   err_cnt = 0;
	int   tests = 0;
	int   failed = 0;
	int   req_rises = 0;
	logic req_prev = 1'b0;

	always #5 clk = ~clk;

	icache_top icache_top_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.cpu_re    (cpu_re),
		.cpu_addr  (cpu_addr),
		.cpu_stall (cpu_stall),
		.cpu_rdata (cpu_rdata),
		.bus_req   (bus_req),
		.bus_grnt  (bus_grnt),
		.ar        (ar),
		.ar_valid  (ar_valid),
		.ar_ready  (ar_ready),
		.r         (r),
		.r_valid   (r_valid),
		.r_ready   (r_ready)
	);

	bind icache_top icache_assertions assertions_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.cpu_re    (cpu_re),
		.cpu_addr  (cpu_addr),
		.cpu_stall (cpu_stall),
		.cpu_rdata (cpu_rdata),
		.bus_req   (bus_req),
		.ar        (ar),
		.ar_valid  (ar_valid),
		.ar_ready  (ar_ready),
		.r         (r),
		.r_valid   (r_valid),
		.r_ready   (r_ready)
	);

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// n fresh bits, one step per bit
	function automatic int unsigned draw(input int n);
		int unsigned v;
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_q = lfsr_step(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	function automatic logic [31:0] line_addr(input logic [19:0] tag, input logic [5:0] index,
		input logic [3:0] word);
		return {tag, index, word, 2'b00};
	endfunction

	function automatic int total_errs();
		return err_cnt + icache_top_i.assertions_i.fail_cnt;
	endfunction

	// memory side: grant, ar_ready and beats after random delays
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			bus_grnt  <= 1'b0;
			ar_ready  <= 1'b0;
			r_valid   <= 1'b0;
			mem_phase <= 2'd0;
		end
		else
		begin
			case (mem_phase)
				2'd0:
				begin
					if (bus_req)
					begin
						mem_cnt   <= draw(2);
						mem_phase <= 2'd1;
					end
				end
				2'd1:
				begin
					// grant after 0 to 3 cycles
					if (mem_cnt == 0)
					begin
						bus_grnt  <= 1'b1;
						mem_cnt   <= draw(2);
						mem_phase <= 2'd2;
					end
					else
					begin
						mem_cnt <= mem_cnt - 1;
					end
				end
				2'd2:
				begin
					if (ar_valid && ar_ready)
					begin
						ar_ready  <= 1'b0;
						mem_base  <= ar.addr;
						mem_beat  <= '0;
						mem_phase <= 2'd3;
					end
					else if (ar_valid && mem_cnt == 0)
					begin
						ar_ready <= 1'b1;
					end
					else if (ar_valid)
					begin
						mem_cnt <= mem_cnt - 1;
					end
				end
				default:
				begin
					// r_ready is high all through the data phase
					if (r_valid && r.last)
					begin
						r_valid   <= 1'b0;
						bus_grnt  <= 1'b0;
						mem_phase <= 2'd0;
					end
					else if (draw(1) == 1)
					begin
						r_valid  <= 1'b1;
						r        <= {~(mem_base + (mem_beat << 2)), mem_beat == 32'd15};
						mem_beat <= mem_beat + 1;
					end
					else
					begin
						// gap cycle
						r_valid <= 1'b0;
					end
				end
			endcase
		end
	end

	// count refills by bus_req rises
	always @(negedge clk)
	begin
		if (rst_n && bus_req && !req_prev)
		begin
			req_rises = req_rises + 1;
		end
		req_prev = bus_req;
	end

	task automatic flag_error(input string msg);
		err_cnt++;
		$display("ERR %0t: %s", $time, msg);
	endtask

	// one read, held until accepted; returns the stall cycles seen
	task automatic fetch(input logic [31:0] addr, output int stall_cycles);
		int   guard;
		logic stalled;
		cpu_re       <= 1'b1;
		cpu_addr     <= addr;
		stall_cycles = 0;
		guard        = 0;
		do
		begin
			@(negedge clk);
			stalled = cpu_stall;
			if (stalled)
			begin
				stall_cycles++;
			end
			guard++;
			@(posedge clk);
		end while (stalled && guard < 200);
		if (stalled)
		begin
			$display("timeout: read of %h still stalled after 200 cycles", addr);
			$display("TEST FAILED");
			$finish;
		end
	endtask

	task automatic idle(input int n);
		cpu_re <= 1'b0;
		repeat (n) @(posedge clk);
	endtask

	task automatic report_test(input string name, input int start);
		int errs;
		errs = total_errs() - start;
		tests++;
		if (errs != 0)
		begin
			failed++;
		end
		$display("test %0d %s: %s", tests, name, (errs == 0) ? "pass" : "fail");
	endtask

	initial
	begin
		int start;
		int rises;
		int stalls;
		int total;
		int w;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		// reset state checked by assertion
		start = total_errs();
		idle(3);
		report_test("reset", start);

		// cold miss on index 5
		start = total_errs();
		rises = req_rises;
		fetch(line_addr(20'h12345, 6'd5, 4'd3), stalls);
		idle(2);
		if (stalls == 0)
		begin
			flag_error("cold read did not stall");
		end
		if (req_rises - rises != 1)
		begin
			flag_error($sformatf("%0d bus requests on a cold miss", req_rises - rises));
		end
		report_test("cold miss", start);

		// all 16 words back to back
		start = total_errs();
		total = 0;
		for (w = 0; w < 16; w++)
		begin
			fetch(line_addr(20'h12345, 6'd5, 4'(w)), stalls);
			total += stalls;
		end
		idle(2);
		if (total != 0)
		begin
			flag_error("stall during back to back reads of a filled line");
		end
		report_test("line data", start);

		// scattered re-reads must all hit
		start = total_errs();
		rises = req_rises;
		total = 0;
		for (w = 15; w >= 0; w -= 3)
		begin
			fetch(line_addr(20'h12345, 6'd5, 4'(w)), stalls);
			total += stalls;
			idle(1);
		end
		idle(1);
		if (total != 0)
		begin
			flag_error("stall on a hit");
		end
		if (req_rises != rises)
		begin
			flag_error("bus_req raised on a hit");
		end
		report_test("hits", start);

		// A B A C on index 9, C must evict B
		start = total_errs();
		rises = req_rises;
		fetch(line_addr(20'h0a000, 6'd9, 4'd1), stalls);
		idle(1);
		fetch(line_addr(20'h0b000, 6'd9, 4'd2), stalls);
		idle(1);
		fetch(line_addr(20'h0a000, 6'd9, 4'd4), stalls);
		idle(1);
		fetch(line_addr(20'h0c000, 6'd9, 4'd8), stalls);
		idle(1);
		fetch(line_addr(20'h0a000, 6'd9, 4'd0), stalls);
		idle(1);
		if (stalls != 0)
		begin
			flag_error("line A missed after C was filled");
		end
		fetch(line_addr(20'h0b000, 6'd9, 4'd2), stalls);
		idle(2);
		if (stalls == 0)
		begin
			flag_error("line B still hit after C was filled");
		end
		if (req_rises - rises != 4)
		begin
			flag_error($sformatf("%0d bus requests, expected 4", req_rises - rises));
		end
		report_test("lru", start);

		// one more refill on the top set, end of burst by assertion
		start = total_errs();
		fetch(line_addr(20'h7f00d, 6'd63, 4'd15), stalls);
		idle(2);
		report_test("burst end", start);

		$display("tests %0d, failed %0d, errors %0d", tests, failed, total_errs());
		if (total_errs() == 0)
		begin
			$display("TEST OK");
		end
		else
		begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* icache.f */
common/icache_geom_pkg.sv
common/icache_axi_pkg.sv
rtl/icache_data_ram.sv
rtl/icache_way/icache_way.sv
rtl/icache_lookup.sv
rtl/icache_refill/icache_refill_fsm.sv
rtl/icache_top.sv
dv/icache_assertions.sv
dv/icache_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and judge the log
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module icache_tb -f icache.f -o icache_sim \
	|| { echo "build failed"; exit 1; }
./obj_dir/icache_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST OK" sim.log || { echo "simulation did not finish"; exit 1; }
exit 0
